/* source/npc_settings.svh */
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// Data path width.
`define NPC_XLEN 32

// First fetch address after reset.
`define NPC_RESET_PC 32'h8000_0000

// Architectural registers, x0 included.
`define NPC_REG_COUNT 32

// Data memory depth in 32-bit words.
// Addresses wrap modulo the depth.
`define NPC_DMEM_WORDS 256

`endif

/* source/npc_pkg.sv */
package npc_pkg;

  // Register/immediate layout.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // Store/branch layout with the immediate split around rs1 and rs2.
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r;
    s_view_t s;
  } inst_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_link, wb_load, wb_upper} wb_sel_e;

  typedef enum logic [1:0] {npc_seq, npc_jal, npc_jalr, npc_branch} npc_sel_e;

  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

endpackage

/* source/npc_decoder.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_decoder import npc_pkg::*; (
  input  inst_u                inst,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic [4:0]           rd,
  output logic [`NPC_XLEN-1:0] imm,
  output logic                 use_imm,
  output alu_op_e              alu_op,
  output npc_sel_e             npc_sel,
  output logic [2:0]           br_funct,
  output logic                 reg_wen,
  output wb_sel_e              wb_sel,
  output logic                 mem_ren,
  output logic                 mem_wen,
  output mem_size_e            mem_size,
  output logic                 mem_sext,
  output logic                 is_ebreak
);

  r_view_t r;
  s_view_t s;
  logic [`NPC_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  mem_size_e size_f3;
  logic wen_raw;

  assign r = inst.r;
  assign s = inst.s;

  assign rs1      = r.rs1;
  assign rs2      = r.rs2;
  assign rd       = r.rd;
  assign br_funct = r.funct3;

  assign imm_i = {{20{r.funct7[6]}}, r.funct7, r.rs2};
  assign imm_s = {{20{s.imm_hi[6]}}, s.imm_hi, s.imm_lo};
  assign imm_b = {{19{s.imm_hi[6]}}, s.imm_hi[6], s.imm_lo[0], s.imm_hi[5:0],
                  s.imm_lo[4:1], 1'b0};
  assign imm_u = {r.funct7, r.rs2, r.rs1, r.funct3, 12'b0};
  assign imm_j = {{12{r.funct7[6]}}, r.rs1, r.funct3, r.rs2[0], r.funct7[5:0],
                  r.rs2[4:1], 1'b0};

  // Shared by loads and stores.
  assign size_f3 = (r.funct3[1:0] == 2'b00) ? size_byte :
                   (r.funct3[1:0] == 2'b01) ? size_half : size_word;

  // x0 is never a write target.
  assign reg_wen = wen_raw && (r.rd != 5'd0);

  always_comb begin
    imm       = imm_i;
    use_imm   = 1'b0;
    alu_op    = alu_add;
    npc_sel   = npc_seq;
    wen_raw   = 1'b0;
    wb_sel    = wb_alu;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    mem_size  = size_word;
    mem_sext  = 1'b0;
    is_ebreak = 1'b0;
    case (r.opcode)
      op_imm, op_reg: begin
        use_imm = (r.opcode == op_imm);
        wen_raw = 1'b1;
        case (r.funct3)
          3'b000:  alu_op = (!use_imm && r.funct7[5]) ? alu_sub : alu_add;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: wen_raw = 1'b0; // Shifts are not supported.
        endcase
      end
      op_lui: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        wb_sel  = wb_upper;
        wen_raw = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        wb_sel  = wb_upper; // Core feeds pc as operand a.
        wen_raw = 1'b1;
      end
      op_jal: begin
        imm     = imm_j;
        npc_sel = npc_jal;
        wb_sel  = wb_link;
        wen_raw = 1'b1;
      end
      op_jalr: begin
        use_imm = 1'b1;
        npc_sel = npc_jalr;
        wb_sel  = wb_link;
        wen_raw = 1'b1;
      end
      op_branch: begin
        imm     = imm_b;
        npc_sel = npc_branch;
      end
      op_load: begin
        use_imm  = 1'b1;
        wb_sel   = wb_load;
        mem_ren  = 1'b1;
        mem_size = size_f3;
        mem_sext = !r.funct3[2];
        wen_raw  = 1'b1;
      end
      op_store: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        mem_wen  = 1'b1;
        mem_size = size_f3;
      end
      op_system: begin
        is_ebreak = (r.funct3 == 3'b000) && (imm_i == 32'd1);
      end
      default: ; // No-op.
    endcase
  end

endmodule

/* source/npc_regfile.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [4:0]           rs1,
  input  logic [4:0]           rs2,
  input  logic [4:0]           rd,
  input  logic                 wen,
  input  logic [`NPC_XLEN-1:0] wdata,
  output logic [`NPC_XLEN-1:0] src1,
  output logic [`NPC_XLEN-1:0] src2
);

  logic [`NPC_XLEN-1:0] regs [`NPC_REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NPC_REG_COUNT; i++) regs[i] <= '0;
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // Asynchronous reads.
  assign src1 = regs[rs1];
  assign src2 = regs[rs2];

endmodule

/* source/npc_alu.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_alu import npc_pkg::*; (
  input  alu_op_e              alu_op,
  input  logic [`NPC_XLEN-1:0] operand_a,
  input  logic [`NPC_XLEN-1:0] operand_b,
  input  logic                 use_imm,
  input  logic [`NPC_XLEN-1:0] imm,
  output logic [`NPC_XLEN-1:0] result
);

  logic [`NPC_XLEN-1:0] b;

  assign b = use_imm ? imm : operand_b;

  always_comb begin
    case (alu_op)
      alu_add:    result = operand_a + b;
      alu_sub:    result = operand_a - b;
      alu_and:    result = operand_a & b;
      alu_or:     result = operand_a | b;
      alu_xor:    result = operand_a ^ b;
      alu_slt:    result = {31'b0, $signed(operand_a) < $signed(b)};
      alu_sltu:   result = {31'b0, operand_a < b};
      alu_pass_b: result = b; // lui.
      default:    result = operand_a + b;
    endcase
  end

endmodule

/* source/npc_branch_unit.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_branch_unit import npc_pkg::*; (
  input  logic [`NPC_XLEN-1:0] pc,
  input  logic [`NPC_XLEN-1:0] src1,
  input  logic [`NPC_XLEN-1:0] src2,
  input  logic [`NPC_XLEN-1:0] imm,
  input  npc_sel_e             npc_sel,
  input  logic [2:0]           br_funct,
  input  logic [`NPC_XLEN-1:0] alu_result,
  output logic [`NPC_XLEN-1:0] next_pc,
  output logic [`NPC_XLEN-1:0] link
);

  logic taken;
  logic [`NPC_XLEN-1:0] target;

  assign link   = pc + 32'd4;
  assign target = pc + imm;

  always_comb begin
    case (br_funct)
      3'b000:  taken = (src1 == src2);
      3'b001:  taken = (src1 != src2);
      3'b100:  taken = $signed(src1) < $signed(src2);
      3'b101:  taken = $signed(src1) >= $signed(src2);
      default: taken = 1'b0; // Unsigned compares left out.
    endcase
  end

  always_comb begin
    case (npc_sel)
      npc_jal:    next_pc = target;
      npc_jalr:   next_pc = {alu_result[`NPC_XLEN-1:1], 1'b0};
      npc_branch: next_pc = taken ? target : link;
      default:    next_pc = link;
    endcase
  end

endmodule

/* source/npc_mem_wb.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_mem_wb import npc_pkg::*; (
  input  logic                 clk,
  input  logic [`NPC_XLEN-1:0] addr,
  input  logic [`NPC_XLEN-1:0] wdata,
  input  logic                 mem_ren,
  input  logic                 mem_wen,
  input  mem_size_e            mem_size,
  input  logic                 mem_sext,
  input  wb_sel_e              wb_sel,
  input  logic [`NPC_XLEN-1:0] alu_result,
  input  logic [`NPC_XLEN-1:0] link,
  output logic [`NPC_XLEN-1:0] rd_wdata
);

  localparam int IDX_W = $clog2(`NPC_DMEM_WORDS);

  logic [`NPC_XLEN-1:0] mem [`NPC_DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [3:0] be;
  logic [`NPC_XLEN-1:0] lane_wdata, word, load_data;
  logic [7:0] rd_byte;
  logic [15:0] rd_half;

  assign idx = addr[IDX_W+1:2];

  always_comb begin
    case (mem_size)
      size_byte: begin
        be         = 4'b0001 << addr[1:0];
        lane_wdata = {4{wdata[7:0]}};
      end
      size_half: begin
        be         = addr[1] ? 4'b1100 : 4'b0011;
        lane_wdata = {2{wdata[15:0]}};
      end
      default: begin
        be         = 4'b1111;
        lane_wdata = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (mem_wen && be[i]) mem[idx][i*8 +: 8] <= lane_wdata[i*8 +: 8];
    end
  end

  assign word    = mem[idx];
  assign rd_byte = word[addr[1:0]*8 +: 8];
  assign rd_half = addr[1] ? word[31:16] : word[15:0];

  always_comb begin
    if (!mem_ren) load_data = '0;
    else if (mem_size == size_byte) load_data = {{24{mem_sext & rd_byte[7]}}, rd_byte};
    else if (mem_size == size_half) load_data = {{16{mem_sext & rd_half[15]}}, rd_half};
    else load_data = word;
  end

  always_comb begin
    case (wb_sel)
      wb_link: rd_wdata = link;
      wb_load: rd_wdata = load_data;
      default: rd_wdata = alu_result; // ALU ops and upper immediates.
    endcase
  end

endmodule

/* source/npc_core.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_core import npc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  output logic [`NPC_XLEN-1:0] imem_addr,
  input  logic [`NPC_XLEN-1:0] imem_data,
  output logic                 commit_valid,
  output logic [`NPC_XLEN-1:0] commit_pc,
  output logic                 commit_wen,
  output logic [4:0]           commit_rd,
  output logic [`NPC_XLEN-1:0] commit_wdata,
  output logic                 halt
);

  logic [`NPC_XLEN-1:0] pc, next_pc, link;
  inst_u inst;
  logic [4:0] rs1, rs2, rd;
  logic [`NPC_XLEN-1:0] imm, src1, src2, operand_a, alu_result, rd_wdata;
  logic use_imm, reg_wen, mem_ren, mem_wen, mem_sext, is_ebreak;
  alu_op_e alu_op;
  npc_sel_e npc_sel;
  wb_sel_e wb_sel;
  mem_size_e mem_size;
  logic [2:0] br_funct;

  assign imem_addr = pc;
  assign inst      = imem_data;

  // auipc adds the pc, lui passes the immediate through.
  assign operand_a = (wb_sel == wb_upper && alu_op == alu_add) ? pc : src1;

  assign commit_valid = !rst && !halt;
  assign commit_pc    = pc;
  assign commit_wen   = commit_valid && reg_wen;
  assign commit_rd    = rd;
  assign commit_wdata = rd_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `NPC_RESET_PC;
      halt <= 1'b0;
    end else if (commit_valid) begin
      pc   <= is_ebreak ? pc : next_pc; // Freeze on ebreak.
      halt <= is_ebreak;
    end
  end

  npc_decoder u_decoder (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .use_imm(use_imm),
    .alu_op(alu_op), .npc_sel(npc_sel), .br_funct(br_funct), .reg_wen(reg_wen),
    .wb_sel(wb_sel), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_size(mem_size),
    .mem_sext(mem_sext), .is_ebreak(is_ebreak)
  );

  npc_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wen(commit_wen), .wdata(rd_wdata), .src1(src1), .src2(src2)
  );

  npc_alu u_alu (
    .alu_op(alu_op), .operand_a(operand_a), .operand_b(src2),
    .use_imm(use_imm), .imm(imm), .result(alu_result)
  );

  npc_branch_unit u_branch (
    .pc(pc), .src1(src1), .src2(src2), .imm(imm), .npc_sel(npc_sel),
    .br_funct(br_funct), .alu_result(alu_result), .next_pc(next_pc), .link(link)
  );

  npc_mem_wb u_mem_wb (
    .clk(clk), .addr(alu_result), .wdata(src2), .mem_ren(mem_ren),
    .mem_wen(mem_wen && commit_valid), .mem_size(mem_size), .mem_sext(mem_sext),
    .wb_sel(wb_sel), .alu_result(alu_result), .link(link), .rd_wdata(rd_wdata)
  );

endmodule

/* tb/npc_checker.sv */
`timescale 1ns/1ps

module npc_checker (
  input logic       clk,
  input logic       rst,
  input logic       commit_valid,
  input logic       commit_wen,
  input logic [4:0] commit_rd,
  input logic       halt
);

  no_commit_in_reset: assert property (@(posedge clk) rst |-> !commit_valid)
    else $error("commit_valid high while rst is asserted");

  // Sticky until the next reset.
  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without a reset");

  wen_needs_rd: assert property (@(posedge clk) commit_wen |-> commit_rd != 5'd0)
    else $error("commit_wen high with commit_rd equal to x0");

endmodule

bind npc_core npc_checker u_checker (
  .clk(clk), .rst(rst), .commit_valid(commit_valid), .commit_wen(commit_wen),
  .commit_rd(commit_rd), .halt(halt)
);

/* tb/npc_tb.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_tb;

  localparam int PROG_WORDS   = 64;
  localparam int MAX_RECORDS  = 48;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;

  logic clk;
  logic rst;
  logic [`NPC_XLEN-1:0] imem_addr;
  logic [`NPC_XLEN-1:0] imem_data;
  logic commit_valid;
  logic [`NPC_XLEN-1:0] commit_pc;
  logic commit_wen;
  logic [4:0] commit_rd;
  logic [`NPC_XLEN-1:0] commit_wdata;
  logic halt;

  logic [31:0] trace_words [256];
  logic [31:0] prog [PROG_WORDS];
  logic [31:0] records [MAX_RECORDS][4]; // pc, wen, rd, wdata.
  int rec_count = 0;
  int rec_idx = 0;
  int mismatches = 0;
  int extra_commits = 0;

  npc_core DUT (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_wen(commit_wen),
    .commit_rd(commit_rd), .commit_wdata(commit_wdata), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got %h, expected %h at %0t", name, actual, expected, $time);
      mismatches++;
    end
  endtask

  task automatic print_counts();
    int missing;
    missing = (rec_idx < rec_count) ? rec_count - rec_idx : 0;
    $display("Mismatches: %0d, unexpected commits: %0d, missing commits: %0d",
             mismatches, extra_commits, missing);
  endtask

  // Program at word 0, records from word 64 until a zero pc.
  task automatic load_trace();
    for (int i = 0; i < 256; i++) begin
      trace_words[i] = '0;
    end
    $readmemh("tb/npc_trace.txt", trace_words);
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = trace_words[i];
    end
    for (int r = 0; r < MAX_RECORDS; r++) begin
      if (rec_count == r && trace_words[PROG_WORDS + 4*r] != '0) begin
        for (int f = 0; f < 4; f++) begin
          records[r][f] = trace_words[PROG_WORDS + 4*r + f];
        end
        rec_count++;
      end
    end
  endtask

  // Instruction port answers for the pc seen at the falling edge.
  initial begin
    logic [31:0] offset;
    imem_data = '0;
    forever begin
      @(negedge clk);
      offset = (imem_addr - `NPC_RESET_PC) >> 2;
      imem_data = (offset < PROG_WORDS) ? prog[offset[5:0]] : '0;
    end
  end

  always @(posedge clk) begin
    if (commit_valid) begin
      if (rec_idx < rec_count) begin
        compare_value("commit_pc", commit_pc, records[rec_idx][0]);
        compare_value("commit_wen", {31'b0, commit_wen}, records[rec_idx][1]);
        if (records[rec_idx][1][0]) begin
          compare_value("commit_rd", {27'b0, commit_rd}, records[rec_idx][2]);
          compare_value("commit_wdata", commit_wdata, records[rec_idx][3]);
        end
      end else begin
        $display("Unexpected commit at pc %h after the last expected record", commit_pc);
        extra_commits++;
      end
      rec_idx++;
    end
  end

  initial begin
    bit short_run;
    rst = 1'b1;
    load_trace();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    wait (halt === 1'b1);
    // Quiet window after halt, pc held on the ebreak.
    repeat (8) begin
      @(negedge clk);
      compare_value("halt", {31'b0, halt}, 32'd1);
      if (rec_count > 0) begin
        compare_value("imem_addr", imem_addr, records[rec_count - 1][0]);
      end
    end
    short_run = (rec_idx < rec_count);
    if (short_run) begin
      $display("Core halted after %0d of %0d expected commits", rec_idx, rec_count);
    end
    print_counts();
    if (mismatches == 0 && extra_commits == 0 && !short_run) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #1;
    #((rec_count + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired at %0t because the core did not halt", $time);
    print_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tb/npc_trace.txt */
// Program words from address 0 in pc order, one word per instruction.
// Commit records from address 40 hex as pc, wen, rd, wdata, two records to a line.
@0
00500093 FFD00113 002081B3 40208233 0020F2B3 0020E333 0020C3B3 00112433
001134B3 FFE12513 FFF0B593 7FF0C613 0F017693 0300E713 00108013 123457B7
00001817 008008EF 00100F93 00000917 00D909E7 00100F93 00108463 00100F93
00109463 00114463 00100F93 00115463 0020D463 00100F93 10602023 10C01123
10100023 10002A03 10001A83 10205B03 10100B83 10104C03 00100073
@40
80000000 1 01 00000005  80000004 1 02 FFFFFFFD
80000008 1 03 00000002  8000000C 1 04 00000008
80000010 1 05 00000005  80000014 1 06 FFFFFFFD
80000018 1 07 FFFFFFF8  8000001C 1 08 00000001
80000020 1 09 00000000  80000024 1 0A 00000001
80000028 1 0B 00000001  8000002C 1 0C 000007FA
80000030 1 0D 000000F0  80000034 1 0E 00000035
80000038 0 00 00000000  8000003C 1 0F 12345000
80000040 1 10 80001040  80000044 1 11 80000048
8000004C 1 12 8000004C  80000050 1 13 80000054
80000058 0 00 00000000  80000060 0 00 00000000
80000064 0 00 00000000  8000006C 0 00 00000000
80000070 0 00 00000000  80000078 0 00 00000000
8000007C 0 00 00000000  80000080 0 00 00000000
80000084 1 14 07FAFF05  80000088 1 15 FFFFFF05
8000008C 1 16 000007FA  80000090 1 17 FFFFFFFF
80000094 1 18 000000FF  80000098 0 00 00000000

/* compile.f */
+incdir+source
source/npc_pkg.sv
source/npc_decoder.sv
source/npc_regfile.sv
source/npc_alu.sv
source/npc_branch_unit.sv
source/npc_mem_wb.sv
source/npc_core.sv
tb/npc_checker.sv
tb/npc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module npc_tb
status=0
./obj_dir/Vnpc_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
